// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // pc and bus data width
    localparam int unsigned XLEN = 64;
    localparam int unsigned ILEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // instruction queue geometry
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_AW = 2;

    // size code for a full 64-bit read
    localparam logic [7:0] BUS_SIZE = 8'h0F;

    // one instruction word, seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo5;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       b12;
            logic [5:0] b10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] b4_1;
            logic       b11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       j20;
            logic [9:0] j10_1;
            logic       j11;
            logic [7:0] j19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

    // coarse class, picked from the opcode
    typedef enum logic [3:0] {
        CLS_ALU, CLS_ALU_IMM, CLS_LOAD, CLS_STORE,
        CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_LUI,
        CLS_AUIPC, CLS_SYSTEM, CLS_ILLEGAL
    } inst_class_e;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_unit (
    input  wire                          clk,
    input  wire                          rst_n_i,
    // read address channel
    output logic                         ar_valid_o,
    input  wire                          ar_ready_i,
    output logic [fetch_pkg::XLEN-1:0]   ar_addr_o,
    output logic [7:0]                   ar_size_o,
    // read data channel
    input  wire                          r_valid_i,
    output logic                         r_ready_o,
    input  wire  [fetch_pkg::XLEN-1:0]   r_data_i,
    // redirects
    input  wire                          redirect_i,
    input  wire  [fetch_pkg::XLEN-1:0]   redirect_pc_i,
    input  wire                          jal_redirect_i,
    input  wire  [fetch_pkg::XLEN-1:0]   jal_target_i,
    // queue push side
    input  wire                          full_i,
    output logic                         push_o,
    output logic [fetch_pkg::XLEN-1:0]   push_pc_o,
    output logic [fetch_pkg::ILEN-1:0]   push_inst_o
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_HOLD} state_e;

    state_e           state_q;
    logic [XLEN-1:0]  pc_q;
    logic [XLEN-1:0]  pc_d;
    logic [XLEN-1:0]  addr_q;
    logic             drop_q;
    logic             hold_valid_q;
    logic [XLEN-1:0]  hold_pc_q;
    logic [ILEN-1:0]  hold_inst_q;
    logic             beat;
    logic             redir;
    logic [XLEN-1:0]  redir_pc;
    logic             slot_free;

    assign beat      = r_valid_i && r_ready_o;
    // the external redirect wins over a jal in the same cycle
    assign redir     = redirect_i || jal_redirect_i;
    assign redir_pc  = redirect_i ? redirect_pc_i : jal_target_i;
    // held entry slot is free next cycle
    assign slot_free = !hold_valid_q || push_o || redir;

    assign ar_valid_o  = (state_q == S_ADDR);
    assign ar_addr_o   = addr_q;
    assign ar_size_o   = BUS_SIZE;
    assign r_ready_o   = (state_q == S_DATA);
    assign push_o      = hold_valid_q && !full_i;
    assign push_pc_o   = hold_pc_q;
    assign push_inst_o = hold_inst_q;

    // next fetch pc
    always_comb begin
        pc_d = pc_q;
        if (redir) begin
            pc_d = redir_pc;
        end else if (beat && !drop_q) begin
            pc_d = pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= S_IDLE;
            pc_q         <= RESET_PC;
            addr_q       <= RESET_PC;
            drop_q       <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            pc_q <= pc_d;
            case (state_q)
                S_IDLE: begin
                    state_q <= S_ADDR;
                    addr_q  <= pc_d;
                end
                S_ADDR: begin
                    if (ar_ready_i) begin
                        state_q <= slot_free ? S_DATA : S_HOLD;
                    end
                end
                // address taken, waiting for the held entry to drain
                S_HOLD: begin
                    if (slot_free) begin
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (beat) begin
                        state_q <= S_ADDR;
                        addr_q  <= pc_d;
                    end
                end
                default: state_q <= S_IDLE;
            endcase

            // a redirect with a read in flight makes its beat stale
            if (beat) begin
                drop_q <= 1'b0;
            end else if (redir && state_q != S_IDLE) begin
                drop_q <= 1'b1;
            end

            if (beat && !drop_q && !redir) begin
                hold_valid_q <= 1'b1;
            end else if (push_o || redir) begin
                hold_valid_q <= 1'b0;
            end
        end
    end

    // half select by address bit 2
    always_ff @(posedge clk) begin
        if (beat) begin
            hold_pc_q   <= addr_q;
            hold_inst_q <= addr_q[2] ? r_data_i[XLEN-1:ILEN] : r_data_i[ILEN-1:0];
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    // a beat never lands on an entry that is still waiting to be pushed
    a_hold_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n_i)
        beat |-> !hold_valid_q);

endmodule

`default_nettype wire

// File: hw/inst_queue.sv
`default_nettype none
`timescale 1ns/10ps

module inst_queue (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          flush_i,
    input  wire                          push_i,
    input  wire  [fetch_pkg::XLEN-1:0]   push_pc_i,
    input  wire  [fetch_pkg::ILEN-1:0]   push_inst_i,
    output logic                         full_o,
    input  wire                          pop_i,
    output logic                         empty_o,
    output logic [fetch_pkg::XLEN-1:0]   head_pc_o,
    output logic [fetch_pkg::ILEN-1:0]   head_inst_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0]   pc_mem   [QUEUE_DEPTH];
    logic [ILEN-1:0]   inst_mem [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr_q;
    logic [QUEUE_AW-1:0] rd_ptr_q;
    logic [QUEUE_AW:0]   count_q;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == (QUEUE_AW+1)'(QUEUE_DEPTH));
    assign empty_o = (count_q == '0);

    // flush discards anything pushed or popped alongside it
    assign do_push = push_i && !full_o && !flush_i;
    assign do_pop  = pop_i && !empty_o && !flush_i;

    assign head_pc_o   = pc_mem[rd_ptr_q];
    assign head_inst_o = inst_mem[rd_ptr_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (QUEUE_AW+1)'(do_push) - (QUEUE_AW+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]   <= push_pc_i;
            inst_mem[wr_ptr_q] <= push_inst_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
`default_nettype none
`timescale 1ns/10ps

module inst_decode (
    input  wire                          clk,
    input  wire                          rst_n_i,
    // queue head
    input  wire                          empty_i,
    input  wire  [fetch_pkg::XLEN-1:0]   head_pc_i,
    input  wire  [fetch_pkg::ILEN-1:0]   head_inst_i,
    output logic                         pop_o,
    // redirects
    input  wire                          redirect_i,
    output logic                         jal_redirect_o,
    output logic [fetch_pkg::XLEN-1:0]   jal_target_o,
    // decoded instruction
    output logic                         dec_valid_o,
    input  wire                          dec_ready_i,
    output logic [fetch_pkg::XLEN-1:0]   dec_pc_o,
    output logic [fetch_pkg::ILEN-1:0]   dec_inst_o,
    output fetch_pkg::inst_class_e       dec_class_o,
    output logic [4:0]                   dec_rd_o,
    output logic [4:0]                   dec_rs1_o,
    output logic [4:0]                   dec_rs2_o,
    output logic [fetch_pkg::XLEN-1:0]   dec_imm_o
);
    import fetch_pkg::*;

    inst_t            inst;
    inst_class_e      cls_d;
    logic [4:0]       rd_d;
    logic [4:0]       rs1_d;
    logic [4:0]       rs2_d;
    logic [XLEN-1:0]  imm_d;

    assign inst = head_inst_i;

    // head moves when the output slot is free or draining, never under redirect
    assign pop_o = !empty_i && (!dec_valid_o || dec_ready_i) && !redirect_i;

    always_comb begin
        case (inst.r.opcode)
            7'b0110011, 7'b0111011: cls_d = CLS_ALU;
            7'b0010011, 7'b0011011: cls_d = CLS_ALU_IMM;
            7'b0000011:             cls_d = CLS_LOAD;
            7'b0100011:             cls_d = CLS_STORE;
            7'b1100011:             cls_d = CLS_BRANCH;
            7'b1101111:             cls_d = CLS_JAL;
            7'b1100111:             cls_d = CLS_JALR;
            7'b0110111:             cls_d = CLS_LUI;
            7'b0010111:             cls_d = CLS_AUIPC;
            7'b1110011:             cls_d = CLS_SYSTEM;
            default:                cls_d = CLS_ILLEGAL;
        endcase
    end

    // fields the format lacks read as zero
    always_comb begin
        rd_d  = inst.r.rd;
        rs1_d = inst.r.rs1;
        rs2_d = inst.r.rs2;
        imm_d = '0;
        case (cls_d)
            CLS_ALU: ;
            CLS_ALU_IMM, CLS_LOAD, CLS_JALR, CLS_SYSTEM: begin
                rs2_d = '0;
                imm_d = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
            end
            CLS_STORE: begin
                rd_d  = '0;
                imm_d = {{(XLEN-12){inst.s.imm_hi7[6]}}, inst.s.imm_hi7, inst.s.imm_lo5};
            end
            CLS_BRANCH: begin
                rd_d  = '0;
                imm_d = {{(XLEN-13){inst.b.b12}}, inst.b.b12, inst.b.b11,
                         inst.b.b10_5, inst.b.b4_1, 1'b0};
            end
            CLS_LUI, CLS_AUIPC: begin
                rs1_d = '0;
                rs2_d = '0;
                imm_d = {{(XLEN-32){inst.u.imm20[19]}}, inst.u.imm20, 12'h000};
            end
            CLS_JAL: begin
                rs1_d = '0;
                rs2_d = '0;
                imm_d = {{(XLEN-21){inst.j.j20}}, inst.j.j20, inst.j.j19_12,
                         inst.j.j11, inst.j.j10_1, 1'b0};
            end
            default: begin
                rd_d  = '0;
                rs1_d = '0;
                rs2_d = '0;
            end
        endcase
    end

    // jal resolved here, fetch steered at the pop edge
    assign jal_redirect_o = pop_o && (cls_d == CLS_JAL);
    assign jal_target_o   = head_pc_i + imm_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (redirect_i) begin
            dec_valid_o <= 1'b0;
        end else if (pop_o) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            dec_pc_o    <= head_pc_i;
            dec_inst_o  <= head_inst_i;
            dec_class_o <= cls_d;
            dec_rd_o    <= rd_d;
            dec_rs1_o   <= rs1_d;
            dec_rs2_o   <= rs2_d;
            dec_imm_o   <= imm_d;
        end
    end

    // entries queued behind a jal never reach the head
    a_jal_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        jal_redirect_o |=> empty_i);

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_top (
    input  wire                          clk,
    input  wire                          rst_n_i,
    // instruction memory read bus
    output logic                         ar_valid_o,
    input  wire                          ar_ready_i,
    output logic [fetch_pkg::XLEN-1:0]   ar_addr_o,
    output logic [7:0]                   ar_size_o,
    input  wire                          r_valid_i,
    output logic                         r_ready_o,
    input  wire  [fetch_pkg::XLEN-1:0]   r_data_i,
    // redirect from later stages
    input  wire                          redirect_i,
    input  wire  [fetch_pkg::XLEN-1:0]   redirect_pc_i,
    // decoded instruction
    output logic                         dec_valid_o,
    input  wire                          dec_ready_i,
    output logic [fetch_pkg::XLEN-1:0]   dec_pc_o,
    output logic [fetch_pkg::ILEN-1:0]   dec_inst_o,
    output fetch_pkg::inst_class_e       dec_class_o,
    output logic [4:0]                   dec_rd_o,
    output logic [4:0]                   dec_rs1_o,
    output logic [4:0]                   dec_rs2_o,
    output logic [fetch_pkg::XLEN-1:0]   dec_imm_o
);
    import fetch_pkg::*;

    logic             push;
    logic [XLEN-1:0]  push_pc;
    logic [ILEN-1:0]  push_inst;
    logic             full;
    logic             empty;
    logic             pop;
    logic [XLEN-1:0]  head_pc;
    logic [ILEN-1:0]  head_inst;
    logic             jal_redirect;
    logic [XLEN-1:0]  jal_target;
    logic             flush;

    // any redirect empties the queue
    assign flush = redirect_i || jal_redirect;

    fetch_unit i_fetch_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ar_valid_o     (ar_valid_o),
        .ar_ready_i     (ar_ready_i),
        .ar_addr_o      (ar_addr_o),
        .ar_size_o      (ar_size_o),
        .r_valid_i      (r_valid_i),
        .r_ready_o      (r_ready_o),
        .r_data_i       (r_data_i),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .jal_redirect_i (jal_redirect),
        .jal_target_i   (jal_target),
        .full_i         (full),
        .push_o         (push),
        .push_pc_o      (push_pc),
        .push_inst_o    (push_inst)
    );

    inst_queue i_inst_queue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush),
        .push_i      (push),
        .push_pc_i   (push_pc),
        .push_inst_i (push_inst),
        .full_o      (full),
        .pop_i       (pop),
        .empty_o     (empty),
        .head_pc_o   (head_pc),
        .head_inst_o (head_inst)
    );

    inst_decode i_inst_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .empty_i        (empty),
        .head_pc_i      (head_pc),
        .head_inst_i    (head_inst),
        .pop_o          (pop),
        .redirect_i     (redirect_i),
        .jal_redirect_o (jal_redirect),
        .jal_target_o   (jal_target),
        .dec_valid_o    (dec_valid_o),
        .dec_ready_i    (dec_ready_i),
        .dec_pc_o       (dec_pc_o),
        .dec_inst_o     (dec_inst_o),
        .dec_class_o    (dec_class_o),
        .dec_rd_o       (dec_rd_o),
        .dec_rs1_o      (dec_rs1_o),
        .dec_rs2_o      (dec_rs2_o),
        .dec_imm_o      (dec_imm_o)
    );

endmodule

`default_nettype wire

// File: verification/fetch_tb.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int WAIT_LIMIT = 1000;
    localparam int NUM_CHECKS = 600;

    logic              clk;
    logic              rst_n_i;
    logic              ar_valid_o;
    logic              ar_ready_i;
    logic [XLEN-1:0]   ar_addr_o;
    logic [7:0]        ar_size_o;
    logic              r_valid_i;
    logic              r_ready_o;
    logic [XLEN-1:0]   r_data_i;
    logic              redirect_i;
    logic [XLEN-1:0]   redirect_pc_i;
    logic              dec_valid_o;
    logic              dec_ready_i;
    logic [XLEN-1:0]   dec_pc_o;
    logic [ILEN-1:0]   dec_inst_o;
    inst_class_e       dec_class_o;
    logic [4:0]        dec_rd_o;
    logic [4:0]        dec_rs1_o;
    logic [4:0]        dec_rs2_o;
    logic [XLEN-1:0]   dec_imm_o;

    integer            seed;
    // sparse instruction memory, one 64-bit word per key
    logic [XLEN-1:0]   mem [logic [XLEN-4:0]];

    fetch_top i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ar_valid_o    (ar_valid_o),
        .ar_ready_i    (ar_ready_i),
        .ar_addr_o     (ar_addr_o),
        .ar_size_o     (ar_size_o),
        .r_valid_i     (r_valid_i),
        .r_ready_o     (r_ready_o),
        .r_data_i      (r_data_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .dec_pc_o      (dec_pc_o),
        .dec_inst_o    (dec_inst_o),
        .dec_class_o   (dec_class_o),
        .dec_rd_o      (dec_rd_o),
        .dec_rs1_o     (dec_rs1_o),
        .dec_rs2_o     (dec_rs2_o),
        .dec_imm_o     (dec_imm_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_inst(input string name, input logic [ILEN-1:0] exp,
                              input logic [ILEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_class(input string name, input inst_class_e exp,
                               input inst_class_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %s actual %s", $time, name,
                                exp.name(), act.name()));
        end
    endtask

    task automatic check_imm(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_size(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR t=%0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    // RV64 base opcodes, jal left out on purpose
    function automatic logic [6:0] legal_opcode(input logic [7:0] idx);
        case (idx)
            8'd0:    legal_opcode = 7'b0110011;
            8'd1:    legal_opcode = 7'b0111011;
            8'd2:    legal_opcode = 7'b0010011;
            8'd3:    legal_opcode = 7'b0011011;
            8'd4:    legal_opcode = 7'b0000011;
            8'd5:    legal_opcode = 7'b0100011;
            8'd6:    legal_opcode = 7'b1100011;
            8'd7:    legal_opcode = 7'b1100111;
            8'd8:    legal_opcode = 7'b0110111;
            8'd9:    legal_opcode = 7'b0010111;
            default: legal_opcode = 7'b1110011;
        endcase
    endfunction

    function automatic inst_class_e class_of(input logic [6:0] opc);
        case (opc)
            7'b0110011, 7'b0111011: class_of = CLS_ALU;
            7'b0010011, 7'b0011011: class_of = CLS_ALU_IMM;
            7'b0000011: class_of = CLS_LOAD;
            7'b0100011: class_of = CLS_STORE;
            7'b1100011: class_of = CLS_BRANCH;
            7'b1101111: class_of = CLS_JAL;
            7'b1100111: class_of = CLS_JALR;
            7'b0110111: class_of = CLS_LUI;
            7'b0010111: class_of = CLS_AUIPC;
            7'b1110011: class_of = CLS_SYSTEM;
            default:    class_of = CLS_ILLEGAL;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] imm_of(input logic [31:0] w, input inst_class_e cls);
        case (cls)
            CLS_ALU_IMM, CLS_LOAD, CLS_JALR, CLS_SYSTEM:
                imm_of = {{52{w[31]}}, w[31:20]};
            CLS_STORE:
                imm_of = {{52{w[31]}}, w[31:25], w[11:7]};
            CLS_BRANCH:
                imm_of = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            CLS_LUI, CLS_AUIPC:
                imm_of = {{32{w[31]}}, w[31:12], 12'h000};
            CLS_JAL:
                imm_of = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:
                imm_of = '0;
        endcase
    endfunction

    // {rd, rs1, rs2}, zero where the format has no such field
    function automatic logic [14:0] regs_of(input logic [31:0] w, input inst_class_e cls);
        case (cls)
            CLS_ALU:                                     regs_of = {w[11:7], w[19:15], w[24:20]};
            CLS_ALU_IMM, CLS_LOAD, CLS_JALR, CLS_SYSTEM: regs_of = {w[11:7], w[19:15], 5'd0};
            CLS_STORE, CLS_BRANCH:                       regs_of = {5'd0, w[19:15], w[24:20]};
            CLS_LUI, CLS_AUIPC, CLS_JAL:                 regs_of = {w[11:7], 10'd0};
            default:                                     regs_of = '0;
        endcase
    endfunction

    // word is created on first read and fixed afterwards
    task automatic read_mem(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] word);
        logic [XLEN-4:0] key;
        logic [ILEN-1:0] lo;
        logic [ILEN-1:0] hi;
        logic [ILEN-1:0] jal;
        logic [20:0]     off;
        logic [31:0]     r;
        key = addr[XLEN-1:3];
        if (!mem.exists(key)) begin
            lo = $random(seed);
            hi = $random(seed);
            r  = $random(seed);
            // most halves get a real opcode so every format shows up
            if (r[1:0] != 2'b00) begin
                lo[6:0] = legal_opcode(r[15:8] % 8'd11);
            end
            if (r[3:2] != 2'b00) begin
                hi[6:0] = legal_opcode(r[23:16] % 8'd11);
            end
            // roughly one word in eight carries a short forward jal
            if (r[6:4] == 3'b000) begin
                off = (21'(r[29:25]) + 21'd1) << 2;
                jal = {off[20], off[10:1], off[11], off[19:12], lo[11:7], 7'b1101111};
                if (r[7]) begin
                    hi = jal;
                end else begin
                    lo = jal;
                end
            end
            mem[key] = {hi, lo};
        end
        word = mem[key];
    endtask

    task automatic serve_bus();
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] word;
        logic [31:0]     r;
        int              waited;
        bit              first;
        first = 1'b1;
        forever begin
            waited = 0;
            while (!ar_valid_o) begin
                @(negedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("timeout while waiting for a bus read address");
                end
            end
            addr = ar_addr_o;
            // size code of a full 64-bit read
            check_size("ar_size_o", 8'h0F, ar_size_o);
            if (first) begin
                check_pc("ar_addr_o", RESET_PC, addr);
                first = 1'b0;
            end
            r = $random(seed);
            // address must hold while ready is withheld
            repeat (r[7:0] % 6) begin
                @(negedge clk);
                check_bit("ar_valid_o", 1'b1, ar_valid_o);
                check_pc("ar_addr_o", addr, ar_addr_o);
            end
            ar_ready_i = 1'b1;
            @(negedge clk);
            ar_ready_i = 1'b0;
            read_mem(addr, word);
            repeat (r[15:8] % 6) begin
                @(negedge clk);
            end
            r_valid_i = 1'b1;
            r_data_i  = word;
            waited    = 0;
            while (!r_ready_o) begin
                @(negedge clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("timeout while waiting for r_ready_o on a data beat");
                end
            end
            @(negedge clk);
            r_valid_i = 1'b0;
        end
    endtask

    task automatic check_output(inout logic [XLEN-1:0] pc);
        logic [XLEN-1:0] word;
        logic [ILEN-1:0] inst;
        inst_class_e     cls;
        logic [XLEN-1:0] imm;
        logic [14:0]     regs;
        check_pc("dec_pc_o", pc, dec_pc_o);
        if (!mem.exists(pc[XLEN-1:3])) begin
            abort_run("decoded pc was never read from instruction memory");
        end
        word = mem[pc[XLEN-1:3]];
        inst = pc[2] ? word[63:32] : word[31:0];
        cls  = class_of(inst[6:0]);
        imm  = imm_of(inst, cls);
        regs = regs_of(inst, cls);
        check_inst("dec_inst_o", inst, dec_inst_o);
        check_class("dec_class_o", cls, dec_class_o);
        check_reg("dec_rd_o", regs[14:10], dec_rd_o);
        check_reg("dec_rs1_o", regs[9:5], dec_rs1_o);
        check_reg("dec_rs2_o", regs[4:0], dec_rs2_o);
        check_imm("dec_imm_o", imm, dec_imm_o);
        pc = (cls == CLS_JAL) ? pc + imm : pc + XLEN'(4);
    endtask

    // drives ready and redirects, checks each transfer seen at the coming edge
    task automatic consume_and_check();
        logic [XLEN-1:0] exp_pc;
        logic [31:0]     r;
        int              checked;
        int              idle;
        int              stall;
        exp_pc  = RESET_PC;
        checked = 0;
        idle    = 0;
        stall   = 0;
        while (checked < NUM_CHECKS) begin
            @(negedge clk);
            r = $random(seed);
            if (stall > 0) begin
                dec_ready_i = 1'b0;
                stall--;
            end else begin
                dec_ready_i = (r[7:0] % 10) >= 3;
                if (r[13:8] == 6'd0) begin
                    stall = 10 + r[18:14];
                end
            end
            r = $random(seed);
            redirect_i    = (r[5:0] == 6'd0);
            redirect_pc_i = {RESET_PC[XLEN-1:16], r[21:8], 2'b00};
            if (dec_valid_o && dec_ready_i) begin
                check_output(exp_pc);
                checked++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    abort_run("timeout while waiting for a decoded instruction");
                end
            end
            if (redirect_i) begin
                exp_pc = redirect_pc_i;
            end
        end
    endtask

    initial begin
        seed          = 32'he01b;
        rst_n_i       = 1'b0;
        ar_ready_i    = 1'b0;
        r_valid_i     = 1'b0;
        r_data_i      = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        dec_ready_i   = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bit("ar_valid_o", 1'b0, ar_valid_o);
            check_bit("r_ready_o", 1'b0, r_ready_o);
            check_bit("dec_valid_o", 1'b0, dec_valid_o);
            check_bit("push", 1'b0, i_dut.push);
            check_bit("jal_redirect", 1'b0, i_dut.jal_redirect);
        end
        rst_n_i = 1'b1;
        fork
            serve_bus();
            consume_and_check();
        join_any
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_top.f
hw/fetch_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/inst_decode.sv
hw/fetch_top.sv
verification/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - hw/fetch_pkg.sv
  - hw/fetch_unit.sv
  - hw/inst_queue.sv
  - hw/inst_decode.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - verification/fetch_tb.sv
